// ==== bench/lc3_mem_model.sv ====
// LC-3 memory model
// 64K-word synchronous array with a one-cycle read,
// write on the edge when we is high, and a log of every write

`include "lc3_settings.svh"

module lc3_mem_model (
    input  logic              clk,
    input  lc3_pkg::mem_req_t req,
    output lc3_pkg::word_t    rdata
);

    timeunit 1ns;
    timeprecision 100ps;

    // full address space
    lc3_pkg::word_t    words [0:(1 << `LC3_WORD_W) - 1];
    // write requests in arrival order
    lc3_pkg::mem_req_t log_q [$];

    initial begin
        rdata = '0;
    end

    ////////////////////////////////////////
    // port
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (req.we === 1'b1) begin
            words[req.addr] = req.wdata;
            log_q.push_back(req);
        end else begin
            // address latched here, data shows up next cycle
            rdata <= words[req.addr];
        end
    end

    // zeroed words decode as BR with an empty mask
    task automatic clear();
        for (int i = 0; i < (1 << `LC3_WORD_W); i++) begin
            words[i] = '0;
        end
        log_q.delete();
    endtask

endmodule

// ==== bench/lc3_tb.sv ====
// LC-3 core testbench
// directed programs for operate, branch, jump, addressing
// and reset/no-op behavior, checked through the memory write log

`include "lc3_settings.svh"

module lc3_tb;

    timeunit 1ns;
    timeprecision 100ps;

    // instructions placed over all programs, each costs at most 5 cycles
    localparam int INSTR_TOTAL  = 160;
    localparam int CYCLE_LIMIT  = 5 * INSTR_TOTAL + 200;
    localparam int RESET_CYCLES = 10;

    // branch path markers
    localparam lc3_pkg::word_t MARK_TAKEN = 16'h7A7A;
    localparam lc3_pkg::word_t MARK_FALL  = 16'h0F0F;

    logic              clk;
    logic              rst_n;
    lc3_pkg::mem_req_t mem_req;
    lc3_pkg::word_t    mem_rdata;

    int unsigned       checks;
    int unsigned       errors;
    int unsigned       cycles;
    logic [31:0]       lcg_state;

    // assembler state
    lc3_pkg::word_t    asm_addr;
    lc3_pkg::word_t    halt_at;
    lc3_pkg::instr_u   halt_word;
    int unsigned       log_pos;

    lc3_core dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata)
    );

    lc3_mem_model mem (
        .clk   (clk),
        .req   (mem_req),
        .rdata (mem_rdata)
    );

    always #10 clk = ~clk;

    // watchdog
    initial begin
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= CYCLE_LIMIT) begin
                $display("timeout after %0d cycles, a program never reached its halt loop",
                         cycles);
                $display("TEST RESULT: FAIL");
                $finish;
            end
        end
    end

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////

    task automatic check_word(string name, lc3_pkg::word_t got, lc3_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_req(string name, lc3_pkg::mem_req_t got, lc3_pkg::mem_req_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error %s got we=%h addr=%h wdata=%h expected we=%h addr=%h wdata=%h",
                     name, got.we, got.addr, got.wdata, exp.we, exp.addr, exp.wdata);
        end
    endtask

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic lc3_pkg::word_t next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    function automatic lc3_pkg::word_t sext5(logic [4:0] imm);
        return {{(`LC3_WORD_W - 5){imm[4]}}, imm};
    endfunction

    // add/and/not, register form
    function automatic lc3_pkg::instr_u alu_reg(lc3_pkg::opcode_e op, lc3_pkg::reg_idx_t dr,
                                                lc3_pkg::reg_idx_t sr1, lc3_pkg::reg_idx_t sr2);
        lc3_pkg::instr_u w;
        w.op.opcode   = op;
        w.op.dr       = dr;
        w.op.sr1      = sr1;
        w.op.imm      = 1'b0;
        w.op.operand2 = {2'b00, sr2};
        return w;
    endfunction

    function automatic lc3_pkg::instr_u alu_imm(lc3_pkg::opcode_e op, lc3_pkg::reg_idx_t dr,
                                                lc3_pkg::reg_idx_t sr1, logic [4:0] imm);
        lc3_pkg::instr_u w;
        w.op.opcode   = op;
        w.op.dr       = dr;
        w.op.sr1      = sr1;
        w.op.imm      = 1'b1;
        w.op.operand2 = imm;
        return w;
    endfunction

    // offset taken from the word after the instruction
    function automatic lc3_pkg::instr_u pc_rel(lc3_pkg::opcode_e op, logic [2:0] r,
                                               lc3_pkg::word_t target);
        lc3_pkg::instr_u w;
        w.pcrel.opcode  = op;
        w.pcrel.reg_nzp = r;
        w.pcrel.offset9 = 9'(target - asm_addr - 16'd1);
        return w;
    endfunction

    function automatic lc3_pkg::instr_u base_rel(lc3_pkg::opcode_e op, lc3_pkg::reg_idx_t r,
                                                 lc3_pkg::reg_idx_t base, logic [5:0] off);
        lc3_pkg::instr_u w;
        w.base.opcode  = op;
        w.base.reg_ds  = r;
        w.base.base    = base;
        w.base.offset6 = off;
        return w;
    endfunction

    function automatic lc3_pkg::instr_u jsr_rel(lc3_pkg::word_t target);
        lc3_pkg::instr_u w;
        w.jsr.opcode    = lc3_pkg::OP_JSR;
        w.jsr.long_flag = 1'b1;
        w.jsr.offset11  = 11'(target - asm_addr - 16'd1);
        return w;
    endfunction

    task automatic place(lc3_pkg::instr_u w);
        mem.words[asm_addr] = w;
        asm_addr++;
    endtask

    // BR nzp to itself ends a program
    task automatic place_halt();
        halt_at   = asm_addr;
        halt_word = pc_rel(lc3_pkg::OP_BR, 3'b111, asm_addr);
        place(halt_word);
    endtask

    ////////////////////////////////////////
    // program control
    ////////////////////////////////////////

    // reset goes low first so the core is idle while memory is rewritten
    task automatic start_program();
        @(posedge clk);
        #2;
        rst_n = 1'b0;
        mem.clear();
        log_pos  = 0;
        asm_addr = `LC3_PC_RESET;
    endtask

    task automatic run_program();
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        // request held out of reset is the first fetch
        @(negedge clk);
        check_word("mem_req.addr", mem_req.addr, `LC3_PC_RESET);
        check_bit("mem_req.we", mem_req.we, 1'b0);
        if (mem.log_q.size() != 0) begin
            errors++;
            $display("memory was written while the core was in reset");
        end
        // capture of the halt word, all earlier stores are done
        do begin
            @(negedge clk);
        end while (!((mem_req.addr == halt_at + 16'd1) &&
                     (mem_rdata == lc3_pkg::word_t'(halt_word))));
    endtask

    // next write in the log must be this store
    task automatic expect_store(lc3_pkg::word_t addr, lc3_pkg::word_t data);
        lc3_pkg::mem_req_t exp;
        exp.we    = 1'b1;
        exp.addr  = addr;
        exp.wdata = data;
        if (log_pos >= mem.log_q.size()) begin
            errors++;
            $display("store number %0d to address %h never happened", log_pos, addr);
        end else begin
            check_req("mem_req", mem.log_q[log_pos], exp);
        end
        log_pos++;
    endtask

    task automatic expect_log_end(string test);
        if (mem.log_q.size() != log_pos) begin
            errors++;
            $display("%s test wrote %0d words where %0d were expected",
                     test, mem.log_q.size(), log_pos);
        end
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    // dropped opcodes must leave R1 and memory alone
    task automatic test_reset_noop();
        lc3_pkg::word_t w;
        w = next_rand();
        start_program();
        mem.words[16'h3020] = w;
        // LDI/STI pointer, a real LDI would load ~w
        mem.words[16'h3021] = 16'h3022;
        mem.words[16'h3022] = ~w;
        place(pc_rel(lc3_pkg::OP_LD, 3'd1, 16'h3020));
        place(lc3_pkg::instr_u'(16'hF025));
        place(pc_rel(lc3_pkg::OP_ST, 3'd1, 16'h3030));
        place(pc_rel(lc3_pkg::OP_LDI, 3'd1, 16'h3021));
        place(pc_rel(lc3_pkg::OP_STI, 3'd1, 16'h3021));
        place(pc_rel(lc3_pkg::OP_ST, 3'd1, 16'h3031));
        place(lc3_pkg::instr_u'(16'h8000));
        // reserved opcode
        place(lc3_pkg::instr_u'(16'hDFFF));
        place(pc_rel(lc3_pkg::OP_ST, 3'd1, 16'h3032));
        place_halt();
        run_program();
        expect_store(16'h3030, w);
        expect_store(16'h3031, w);
        expect_store(16'h3032, w);
        expect_log_end("no-op");
    endtask

    task automatic test_operate();
        lc3_pkg::word_t a;
        lc3_pkg::word_t b;
        lc3_pkg::word_t out;
        a   = next_rand();
        b   = next_rand();
        out = 16'h3050;
        start_program();
        mem.words[16'h3040] = a;
        mem.words[16'h3041] = b;
        place(pc_rel(lc3_pkg::OP_LD, 3'd1, 16'h3040));
        place(pc_rel(lc3_pkg::OP_LD, 3'd2, 16'h3041));
        place(alu_reg(lc3_pkg::OP_ADD, 3'd3, 3'd1, 3'd2));
        place(pc_rel(lc3_pkg::OP_ST, 3'd3, out));
        // -13
        place(alu_imm(lc3_pkg::OP_ADD, 3'd3, 3'd1, 5'h13));
        place(pc_rel(lc3_pkg::OP_ST, 3'd3, out + 16'd1));
        place(alu_reg(lc3_pkg::OP_AND, 3'd3, 3'd1, 3'd2));
        place(pc_rel(lc3_pkg::OP_ST, 3'd3, out + 16'd2));
        // -10, keeps the upper bits of a
        place(alu_imm(lc3_pkg::OP_AND, 3'd3, 3'd1, 5'h16));
        place(pc_rel(lc3_pkg::OP_ST, 3'd3, out + 16'd3));
        place(alu_imm(lc3_pkg::OP_NOT, 3'd3, 3'd1, 5'h1F));
        place(pc_rel(lc3_pkg::OP_ST, 3'd3, out + 16'd4));
        place_halt();
        run_program();
        expect_store(out, a + b);
        expect_store(out + 16'd1, a + sext5(5'h13));
        expect_store(out + 16'd2, a & b);
        expect_store(out + 16'd3, a & sext5(5'h16));
        expect_store(out + 16'd4, ~a);
        expect_log_end("operate");
    endtask

    // every mask against a negative, a zero and a positive load
    task automatic test_branches();
        lc3_pkg::word_t vals [3];
        lc3_pkg::word_t v;
        lc3_pkg::word_t slot;
        logic [2:0]     mask;
        logic           taken;
        vals[0] = next_rand() | 16'h8000;
        vals[1] = '0;
        vals[2] = (next_rand() & 16'h7FFF) | 16'h0001;
        start_program();
        for (int k = 0; k < 3; k++) begin
            mem.words[16'h3070 + k] = vals[k];
        end
        mem.words[16'h3073] = MARK_FALL;
        mem.words[16'h3074] = MARK_TAKEN;
        place(pc_rel(lc3_pkg::OP_LD, 3'd5, 16'h3073));
        place(pc_rel(lc3_pkg::OP_LD, 3'd6, 16'h3074));
        for (int k = 0; k < 3; k++) begin
            for (int m = 1; m < 8; m++) begin
                mask = 3'(m);
                slot = 16'h3080 + lc3_pkg::word_t'(k * 7 + m - 1);
                place(pc_rel(lc3_pkg::OP_LD, 3'd1, 16'h3070 + lc3_pkg::word_t'(k)));
                // taken path is the store three words on
                place(pc_rel(lc3_pkg::OP_BR, mask, asm_addr + 16'd3));
                place(pc_rel(lc3_pkg::OP_ST, 3'd5, slot));
                place(pc_rel(lc3_pkg::OP_BR, 3'b111, asm_addr + 16'd2));
                place(pc_rel(lc3_pkg::OP_ST, 3'd6, slot));
            end
        end
        place_halt();
        run_program();
        for (int k = 0; k < 3; k++) begin
            for (int m = 1; m < 8; m++) begin
                mask  = 3'(m);
                slot  = 16'h3080 + lc3_pkg::word_t'(k * 7 + m - 1);
                v     = vals[k];
                taken = (mask[2] && v[`LC3_WORD_W-1]) || (mask[1] && (v == '0)) ||
                        (mask[0] && !v[`LC3_WORD_W-1] && (v != '0));
                expect_store(slot, taken ? MARK_TAKEN : MARK_FALL);
            end
        end
        expect_log_end("branch");
    endtask

    task automatic test_jumps();
        lc3_pkg::word_t mk1;
        lc3_pkg::word_t mk2;
        mk1 = next_rand();
        mk2 = next_rand();
        start_program();
        // JSRR target, JMP target, subroutine markers
        mem.words[16'h3010] = 16'h300D;
        mem.words[16'h3011] = 16'h3008;
        mem.words[16'h3012] = mk1;
        mem.words[16'h3013] = mk2;
        place(pc_rel(lc3_pkg::OP_LD, 3'd2, 16'h3010));
        place(pc_rel(lc3_pkg::OP_LD, 3'd4, 16'h3011));
        place(jsr_rel(16'h300A));
        place(pc_rel(lc3_pkg::OP_ST, 3'd7, 16'h3020));
        place(base_rel(lc3_pkg::OP_JSR, 3'd0, 3'd2, 6'd0));
        place(pc_rel(lc3_pkg::OP_ST, 3'd7, 16'h3021));
        place(base_rel(lc3_pkg::OP_JMP, 3'd0, 3'd4, 6'd0));
        // skipped by the JMP
        place(pc_rel(lc3_pkg::OP_ST, 3'd7, 16'h3022));
        place(pc_rel(lc3_pkg::OP_ST, 3'd5, 16'h3023));
        place_halt();
        // subroutine at 300a
        place(pc_rel(lc3_pkg::OP_LD, 3'd5, 16'h3012));
        place(pc_rel(lc3_pkg::OP_ST, 3'd5, 16'h3024));
        place(base_rel(lc3_pkg::OP_JMP, 3'd0, 3'd7, 6'd0));
        // subroutine at 300d
        place(pc_rel(lc3_pkg::OP_LD, 3'd6, 16'h3013));
        place(pc_rel(lc3_pkg::OP_ST, 3'd6, 16'h3025));
        place(base_rel(lc3_pkg::OP_JMP, 3'd0, 3'd7, 6'd0));
        run_program();
        // return addresses are the words after JSR at 3002 and JSRR at 3004
        expect_store(16'h3024, mk1);
        expect_store(16'h3020, 16'h3002 + 16'd1);
        expect_store(16'h3025, mk2);
        expect_store(16'h3021, 16'h3004 + 16'd1);
        expect_store(16'h3023, mk1);
        expect_log_end("jump");
    endtask

    // offsets of both signs, pc-relative and base-relative
    task automatic test_addressing();
        lc3_pkg::word_t w [4];
        lc3_pkg::word_t base;
        for (int i = 0; i < 4; i++) begin
            w[i] = next_rand();
        end
        base = 16'h3030;
        start_program();
        mem.words[16'h2FF0]       = w[0];
        mem.words[16'h3040]       = w[1];
        mem.words[base - 16'd2]   = w[2];
        mem.words[base + 16'd5]   = w[3];
        place(pc_rel(lc3_pkg::OP_LD, 3'd1, 16'h2FF0));
        place(pc_rel(lc3_pkg::OP_LD, 3'd2, 16'h3040));
        place(pc_rel(lc3_pkg::OP_LEA, 3'd3, base));
        place(base_rel(lc3_pkg::OP_LDR, 3'd4, 3'd3, 6'h3E));
        place(base_rel(lc3_pkg::OP_LDR, 3'd5, 3'd3, 6'd5));
        place(pc_rel(lc3_pkg::OP_ST, 3'd1, 16'h2FF8));
        place(pc_rel(lc3_pkg::OP_ST, 3'd2, 16'h3048));
        place(base_rel(lc3_pkg::OP_STR, 3'd4, 3'd3, 6'h38));
        place(base_rel(lc3_pkg::OP_STR, 3'd5, 3'd3, 6'd12));
        place(pc_rel(lc3_pkg::OP_LEA, 3'd6, 16'h2FE0));
        place(pc_rel(lc3_pkg::OP_ST, 3'd6, 16'h3049));
        place(pc_rel(lc3_pkg::OP_ST, 3'd3, 16'h304A));
        place_halt();
        run_program();
        expect_store(16'h2FF8, w[0]);
        expect_store(16'h3048, w[1]);
        expect_store(base - 16'd8, w[2]);
        expect_store(base + 16'd12, w[3]);
        expect_store(16'h3049, 16'h2FE0);
        expect_store(16'h304A, base);
        expect_log_end("addressing");
    endtask

    ////////////////////////////////////////
    // main
    ////////////////////////////////////////

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        checks    = 0;
        errors    = 0;
        cycles    = 0;
        lcg_state = 32'h4566_4425;
        asm_addr  = `LC3_PC_RESET;
        halt_at   = '0;
        halt_word = '0;
        log_pos   = 0;
        test_reset_noop();
        test_operate();
        test_branches();
        test_jumps();
        test_addressing();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+include
hw/lc3_pkg.sv
hw/lc3_regfile.sv
hw/lc3_operate_unit.sv
hw/lc3_addr_unit.sv
hw/lc3_sequencer.sv
hw/lc3_core.sv
bench/lc3_mem_model.sv
bench/lc3_tb.sv

// ==== hw/lc3_addr_unit.sv ====
// LC-3 address unit
// program counter, effective address for loads, stores and LEA,
// and the target of BR, JMP/RET, JSR and JSRR

`include "lc3_settings.svh"

module lc3_addr_unit (
    input  logic            clk,
    input  logic            rst_n,
    input  lc3_pkg::instr_u ir,
    input  lc3_pkg::word_t  val_a,
    input  logic            pc_inc,
    input  logic            pc_load,
    output lc3_pkg::word_t  pc,
    output lc3_pkg::word_t  eff_addr,
    output lc3_pkg::word_t  jump_target
);

    lc3_pkg::word_t pc_off9;
    lc3_pkg::word_t pc_off11;
    lc3_pkg::word_t base_off6;

    ////////////////////////////////////////
    // offset adders
    ////////////////////////////////////////

    // pc is already incremented by the time ir is valid
    assign pc_off9   = pc + lc3_pkg::word_t'($signed(ir.pcrel.offset9));
    assign pc_off11  = pc + lc3_pkg::word_t'($signed(ir.jsr.offset11));
    // val_a carries the base register
    assign base_off6 = val_a + lc3_pkg::word_t'($signed(ir.base.offset6));

    // effective address
    always_comb begin
        case (ir.base.opcode)
            lc3_pkg::OP_LDR,
            lc3_pkg::OP_STR: eff_addr = base_off6;
            // ld, st, lea
            default:         eff_addr = pc_off9;
        endcase
    end

    // jump target
    always_comb begin
        case (ir.jsr.opcode)
            lc3_pkg::OP_JMP: jump_target = val_a;
            lc3_pkg::OP_JSR: begin
                // jsr vs jsrr
                jump_target = ir.jsr.long_flag ? pc_off11 : val_a;
            end
            // br
            default:         jump_target = pc_off9;
        endcase
    end

    ////////////////////////////////////////
    // program counter
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= lc3_pkg::word_t'(`LC3_PC_RESET);
        end else if (pc_load) begin
            pc <= jump_target;
        end else if (pc_inc) begin
            pc <= pc + 1'b1;
        end
    end

endmodule

// ==== hw/lc3_core.sv ====
// LC-3 core top level
// register file, operate unit, address unit and sequencer
// on one synchronous memory port

module lc3_core (
    input  logic              clk,
    input  logic              rst_n,
    output lc3_pkg::mem_req_t mem_req,
    input  lc3_pkg::word_t    mem_rdata
);

    lc3_pkg::instr_u   ir;
    lc3_pkg::reg_idx_t rd_a;
    lc3_pkg::reg_idx_t rd_b;
    lc3_pkg::word_t    val_a;
    lc3_pkg::word_t    val_b;
    lc3_pkg::wb_t      wb;
    lc3_pkg::word_t    alu_result;
    logic              branch_taken;
    lc3_pkg::word_t    pc;
    lc3_pkg::word_t    eff_addr;
    logic              pc_inc;
    logic              pc_load;

    ////////////////////////////////////////
    // datapath
    ////////////////////////////////////////

    lc3_regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .rd_a  (rd_a),
        .rd_b  (rd_b),
        .wb    (wb),
        .val_a (val_a),
        .val_b (val_b)
    );

    lc3_operate_unit u_operate (
        .clk          (clk),
        .rst_n        (rst_n),
        .ir           (ir),
        .val_a        (val_a),
        .val_b        (val_b),
        .wb           (wb),
        .alu_result   (alu_result),
        .branch_taken (branch_taken)
    );

    // jump target is consumed inside the address unit
    lc3_addr_unit u_addr (
        .clk         (clk),
        .rst_n       (rst_n),
        .ir          (ir),
        .val_a       (val_a),
        .pc_inc      (pc_inc),
        .pc_load     (pc_load),
        .pc          (pc),
        .eff_addr    (eff_addr),
        .jump_target ()
    );

    // control
    lc3_sequencer u_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_rdata    (mem_rdata),
        .alu_result   (alu_result),
        .branch_taken (branch_taken),
        .pc           (pc),
        .eff_addr     (eff_addr),
        .ir           (ir),
        .rd_a         (rd_a),
        .rd_b         (rd_b),
        .val_b        (val_b),
        .wb           (wb),
        .pc_inc       (pc_inc),
        .pc_load      (pc_load),
        .mem_req      (mem_req)
    );

endmodule

// ==== hw/lc3_operate_unit.sv ====
// LC-3 operate unit
// add/and/not datapath, the N/Z/P condition register
// and the branch test against the BR mask

module lc3_operate_unit (
    input  logic            clk,
    input  logic            rst_n,
    input  lc3_pkg::instr_u ir,
    input  lc3_pkg::word_t  val_a,
    input  lc3_pkg::word_t  val_b,
    input  lc3_pkg::wb_t    wb,
    output lc3_pkg::word_t  alu_result,
    output logic            branch_taken
);

    lc3_pkg::word_t operand2;
    lc3_pkg::nzp_t  flags;
    lc3_pkg::nzp_t  flags_nxt;

    ////////////////////////////////////////
    // alu
    ////////////////////////////////////////

    // imm5 sign-extended to a full word
    assign operand2 = ir.op.imm ? lc3_pkg::word_t'($signed(ir.op.operand2)) : val_b;

    always_comb begin
        case (ir.op.opcode)
            lc3_pkg::OP_ADD: alu_result = val_a + operand2;
            lc3_pkg::OP_AND: alu_result = val_a & operand2;
            lc3_pkg::OP_NOT: alu_result = ~val_a;
            // pass sr1 through
            default:         alu_result = val_a;
        endcase
    end

    ////////////////////////////////////////
    // condition codes
    ////////////////////////////////////////

    // derived from whatever word goes to the register file
    assign flags_nxt.n = wb.data[$bits(lc3_pkg::word_t)-1];
    assign flags_nxt.z = (wb.data == '0);
    assign flags_nxt.p = !flags_nxt.n && !flags_nxt.z;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // z set out of reset
            flags <= '{n: 1'b0, z: 1'b1, p: 1'b0};
        end else if (wb.en) begin
            flags <= flags_nxt;
        end
    end

    // mask bit order n,z,p matches the flag struct
    assign branch_taken = |(ir.pcrel.reg_nzp & flags);

endmodule

// ==== hw/lc3_pkg.sv ====
// LC-3 shared types
// words, register numbers, opcodes, the instruction word views
// and the writeback and memory request buses

`include "lc3_settings.svh"

package lc3_pkg;

    typedef logic [`LC3_WORD_W-1:0]    word_t;
    typedef logic [`LC3_REG_IDX_W-1:0] reg_idx_t;

    // full LC-3 opcode map, unsupported ones run as no-op
    typedef enum logic [`LC3_OPCODE_W-1:0] {
        OP_BR   = 4'b0000,
        OP_ADD  = 4'b0001,
        OP_LD   = 4'b0010,
        OP_ST   = 4'b0011,
        OP_JSR  = 4'b0100,
        OP_AND  = 4'b0101,
        OP_LDR  = 4'b0110,
        OP_STR  = 4'b0111,
        OP_RTI  = 4'b1000,
        OP_NOT  = 4'b1001,
        OP_LDI  = 4'b1010,
        OP_STI  = 4'b1011,
        OP_JMP  = 4'b1100,
        OP_RES  = 4'b1101,
        OP_LEA  = 4'b1110,
        OP_TRAP = 4'b1111
    } opcode_e;

    ////////////////////////////////////////
    // instruction formats
    ////////////////////////////////////////

    // add/and/not: operand2 is imm5, or 2'b00 + sr2
    typedef struct packed {
        opcode_e     opcode;
        reg_idx_t    dr;
        reg_idx_t    sr1;
        logic        imm;
        logic [4:0]  operand2;
    } op_view_t;

    // br, ld, st, lea: dr/sr or n/z/p mask in bits 11:9
    typedef struct packed {
        opcode_e     opcode;
        logic [2:0]  reg_nzp;
        logic [8:0]  offset9;
    } pcrel_view_t;

    // ldr, str, jmp, jsrr
    typedef struct packed {
        opcode_e     opcode;
        reg_idx_t    reg_ds;
        reg_idx_t    base;
        logic [5:0]  offset6;
    } base_view_t;

    // jsr when long is set, jsrr otherwise
    typedef struct packed {
        opcode_e     opcode;
        logic        long_flag;
        logic [10:0] offset11;
    } jsr_view_t;

    typedef union packed {
        op_view_t    op;
        pcrel_view_t pcrel;
        base_view_t  base;
        jsr_view_t   jsr;
    } instr_u;

    ////////////////////////////////////////
    // buses
    ////////////////////////////////////////

    typedef struct packed {
        logic n;
        logic z;
        logic p;
    } nzp_t;

    // register writeback
    typedef struct packed {
        logic     en;
        reg_idx_t idx;
        word_t    data;
    } wb_t;

    // memory port, address latched on every edge with we low
    typedef struct packed {
        logic  we;
        word_t addr;
        word_t wdata;
    } mem_req_t;

endpackage

// ==== hw/lc3_regfile.sv ====
// LC-3 register file
// eight general registers, two combinational read ports
// and one synchronous write port fed by the writeback bus

`include "lc3_settings.svh"

module lc3_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  lc3_pkg::reg_idx_t rd_a,
    input  lc3_pkg::reg_idx_t rd_b,
    input  lc3_pkg::wb_t      wb,
    output lc3_pkg::word_t    val_a,
    output lc3_pkg::word_t    val_b
);

    // register storage
    lc3_pkg::word_t regs [`LC3_REG_N];

    ////////////////////////////////////////
    // write port
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // all registers come up zero
            for (int i = 0; i < `LC3_REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en) begin
            regs[wb.idx] <= wb.data;
        end
    end

    ////////////////////////////////////////
    // read ports
    ////////////////////////////////////////

    // no bypass, a write shows up the cycle after
    assign val_a = regs[rd_a];
    assign val_b = regs[rd_b];

endmodule

// ==== hw/lc3_sequencer.sv ====
// LC-3 sequencer
// multicycle FSM and instruction register, merges operate
// and address unit results into writeback, PC control and the
// memory request

`include "lc3_settings.svh"

module lc3_sequencer (
    input  logic               clk,
    input  logic               rst_n,
    input  lc3_pkg::word_t     mem_rdata,
    input  lc3_pkg::word_t     alu_result,
    input  logic               branch_taken,
    input  lc3_pkg::word_t     pc,
    input  lc3_pkg::word_t     eff_addr,
    output lc3_pkg::instr_u    ir,
    output lc3_pkg::reg_idx_t  rd_a,
    output lc3_pkg::reg_idx_t  rd_b,
    input  lc3_pkg::word_t     val_b,
    output lc3_pkg::wb_t       wb,
    output logic               pc_inc,
    output logic               pc_load,
    output lc3_pkg::mem_req_t  mem_req
);

    typedef enum logic [2:0] {
        S_FETCH,
        S_CAPTURE,
        S_EXECUTE,
        S_WAIT,
        S_LOAD,
        S_STORE
    } state_e;

    state_e           state;
    state_e           state_nxt;
    lc3_pkg::opcode_e opcode;
    logic             is_alu;
    logic             is_load;
    logic             is_store;
    logic             is_jump;

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////

    assign opcode   = ir.op.opcode;
    assign is_alu   = (opcode == lc3_pkg::OP_ADD) || (opcode == lc3_pkg::OP_AND) ||
                      (opcode == lc3_pkg::OP_NOT);
    assign is_load  = (opcode == lc3_pkg::OP_LD) || (opcode == lc3_pkg::OP_LDR);
    assign is_store = (opcode == lc3_pkg::OP_ST) || (opcode == lc3_pkg::OP_STR);
    // unconditional transfers
    assign is_jump  = (opcode == lc3_pkg::OP_JMP) || (opcode == lc3_pkg::OP_JSR);

    // port a is sr1 or base, same bits in every format
    assign rd_a = ir.base.base;
    // port b is sr2, or the store source
    assign rd_b = is_store ? ir.base.reg_ds : ir.op.operand2[2:0];

    ////////////////////////////////////////
    // state machine
    ////////////////////////////////////////

    always_comb begin
        case (state)
            S_FETCH:   state_nxt = S_CAPTURE;
            S_CAPTURE: state_nxt = S_EXECUTE;
            S_EXECUTE: begin
                if (is_load) begin
                    state_nxt = S_WAIT;
                end else if (is_store) begin
                    state_nxt = S_STORE;
                end else begin
                    state_nxt = S_FETCH;
                end
            end
            S_WAIT:    state_nxt = S_LOAD;
            default:   state_nxt = S_FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_FETCH;
        end else begin
            state <= state_nxt;
        end
    end

    // fetched word is on mem_rdata during capture
    always_ff @(posedge clk) begin
        if (state == S_CAPTURE) begin
            ir <= mem_rdata;
        end
    end

    ////////////////////////////////////////
    // writeback
    ////////////////////////////////////////

    always_comb begin
        wb = '0;
        if (state == S_EXECUTE) begin
            if (is_alu) begin
                wb.en   = 1'b1;
                wb.idx  = ir.op.dr;
                wb.data = alu_result;
            end else if (opcode == lc3_pkg::OP_LEA) begin
                wb.en   = 1'b1;
                wb.idx  = ir.op.dr;
                wb.data = eff_addr;
            end else if (opcode == lc3_pkg::OP_JSR) begin
                // return address, pc already points past the jsr
                wb.en   = 1'b1;
                wb.idx  = lc3_pkg::reg_idx_t'(`LC3_LINK_REG);
                wb.data = pc;
            end
        end else if (state == S_LOAD) begin
            wb.en   = 1'b1;
            wb.idx  = ir.op.dr;
            wb.data = mem_rdata;
        end
    end

    ////////////////////////////////////////
    // pc control and memory request
    ////////////////////////////////////////

    assign pc_inc  = (state == S_FETCH);
    assign pc_load = (state == S_EXECUTE) &&
                     (is_jump || ((opcode == lc3_pkg::OP_BR) && branch_taken));

    // ea held through wait so the read is repeated for load
    assign mem_req.addr  = ((state == S_FETCH) || (state == S_CAPTURE)) ? pc : eff_addr;
    assign mem_req.we    = (state == S_STORE);
    assign mem_req.wdata = val_b;

endmodule

// ==== include/lc3_settings.svh ====
// LC-3 core settings
// word width, register file size, reset vector and field sizes
// shared by the package, the RTL and the bench

`ifndef LC3_SETTINGS_SVH
`define LC3_SETTINGS_SVH

// data and address width
`define LC3_WORD_W      16

// general registers and the width of a register number
`define LC3_REG_N       8
`define LC3_REG_IDX_W   3

// opcode field width
`define LC3_OPCODE_W    4

// first fetch address and return-address register
`define LC3_PC_RESET    16'h3000
`define LC3_LINK_REG    7

`endif
